// File: common/irq_pkg.sv
// --------------------------------------------------------------------------
// Interrupt-side definitions shared by the pending register, the arbiter,
// the sleep controller and the testbench
// --------------------------------------------------------------------------

package irq_pkg;

  // --------------------------------------------------------------------------
  // Interrupt lines
  // --------------------------------------------------------------------------

  // Number of external interrupt lines
  localparam int unsigned NumIrq = 32;

  // One bit per interrupt line
  typedef logic [NumIrq-1:0] irq_vec_t;

  // Lines that exist are 31..16 (platform), 11 (external), 7 (timer) and 3 (software)
  localparam irq_vec_t ValidIrqMask = 32'hffff_0888;

  // Interrupt number as offered to the core
  typedef logic [4:0] irq_id_t;

  // --------------------------------------------------------------------------
  // Request handshake
  // --------------------------------------------------------------------------

  // Four-phase req/ack states
  //   IDLE         no request, a new winner may be latched
  //   REQ          request high, waiting for ack high
  //   WAIT_ACK_LOW request dropped, waiting for ack low
  typedef enum logic [1:0] {
    IDLE         = 2'b00,
    REQ          = 2'b01,
    WAIT_ACK_LOW = 2'b10
  } irq_req_state_e;

endpackage

// File: common/core_pkg.sv
// --------------------------------------------------------------------------
// Core-side definitions: privilege levels, the WFI encoding and the types
// seen at the writeback stage by the sleep controller
// --------------------------------------------------------------------------

package core_pkg;

  // Privilege levels, RISC-V encoding
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Raw instruction word in writeback
  typedef logic [31:0] instr_t;

  // WFI encoding
  localparam instr_t WfiInstr = 32'h1050_0073;

  // Outstanding instruction-bus transactions
  typedef logic [1:0] outst_cnt_t;

  // Saturating WFI residence counter
  typedef logic [1:0] wfi_cnt_t;

  // Earlier consecutive writeback cycles a WFI needs before sleep
  localparam wfi_cnt_t WfiSleepDelay = 2'd2;

endpackage

// File: hw/irq_ctrl/irq_pending.sv
// --------------------------------------------------------------------------
// Interrupt pending register. Samples the external lines into mip every
// cycle and forms the pending-and-enabled vector for arbitration and wake-up
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module irq_pending (
  input  logic             clk_i,
  input  logic             rst_ni,

  // External interrupt lines
  input  irq_pkg::irq_vec_t irq_i,

  // Machine interrupt enable CSR
  input  irq_pkg::irq_vec_t mie_i,

  // Pending state
  output irq_pkg::irq_vec_t mip_o,
  output irq_pkg::irq_vec_t pend_en_o
);

  irq_pkg::irq_vec_t mip_q;
  irq_pkg::irq_vec_t irq_valid;

  // Reserved lines never reach mip
  assign irq_valid = irq_i & irq_pkg::ValidIrqMask;

  // --------------------------------------------------------------------------
  // Pending register
  // --------------------------------------------------------------------------

  // Level sensitive, so mip follows the lines with one cycle of delay
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_valid;
    end
  end

  assign mip_o = mip_q;

  // Pending and locally enabled
  assign pend_en_o = mip_q & mie_i;

endmodule

// File: hw/irq_ctrl/irq_arbiter.sv
// --------------------------------------------------------------------------
// Interrupt arbiter. Picks the highest-priority pending and enabled line
// and offers its id to the core over a four-phase req/ack handshake
// Priority order is 31 down to 16, then 11, then 3, then 7
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module irq_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Pending and enabled lines
  input  irq_pkg::irq_vec_t     pend_en_i,

  // Global enable state
  input  core_pkg::priv_lvl_e   priv_lvl_i,
  input  logic                  mstatus_mie_i,

  // Core handshake
  output logic                  irq_req_o,
  output irq_pkg::irq_id_t      irq_id_o,
  input  logic                  irq_ack_i
);

  irq_pkg::irq_req_state_e state_q;
  irq_pkg::irq_req_state_e state_d;
  irq_pkg::irq_id_t        id_q;
  irq_pkg::irq_id_t        win_id;
  logic                    win_valid;
  logic                    eligible;

  // --------------------------------------------------------------------------
  // Fixed-priority selection
  // --------------------------------------------------------------------------

  // Lowest priority first so that later matches override earlier ones
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pend_en_i[7]) begin
      win_valid = 1'b1;
      win_id    = 5'd7;
    end
    if (pend_en_i[3]) begin
      win_valid = 1'b1;
      win_id    = 5'd3;
    end
    if (pend_en_i[11]) begin
      win_valid = 1'b1;
      win_id    = 5'd11;
    end
    for (int i = 16; i < irq_pkg::NumIrq; i++) begin
      if (pend_en_i[i]) begin
        win_valid = 1'b1;
        win_id    = irq_pkg::irq_id_t'(i);
      end
    end
  end

  // M-mode needs mstatus.mie, U-mode always takes the interrupt
  assign eligible = win_valid &&
                    (((priv_lvl_i == core_pkg::PRIV_LVL_M) && mstatus_mie_i) ||
                     (priv_lvl_i == core_pkg::PRIV_LVL_U));

  // --------------------------------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      irq_pkg::IDLE: begin
        if (eligible) begin
          state_d = irq_pkg::REQ;
        end
      end
      // Held until ack even if the line withdraws
      irq_pkg::REQ: begin
        if (irq_ack_i) begin
          state_d = irq_pkg::WAIT_ACK_LOW;
        end
      end
      irq_pkg::WAIT_ACK_LOW: begin
        if (!irq_ack_i) begin
          state_d = irq_pkg::IDLE;
        end
      end
      default: state_d = irq_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= irq_pkg::IDLE;
      id_q    <= '0;
    end else begin
      state_q <= state_d;
      // Id is captured on the edge where the request rises
      if ((state_q == irq_pkg::IDLE) && eligible) begin
        id_q <= win_id;
      end
    end
  end

  assign irq_req_o = (state_q == irq_pkg::REQ);
  assign irq_id_o  = id_q;

endmodule

// File: hw/sleep_ctrl/wfi_sleep_ctrl.sv
// --------------------------------------------------------------------------
// WFI sleep controller. Watches the writeback stage for a WFI, counts how
// long it has been there and raises core_sleep_o once the buses are idle
// Also flags when the WFI retires because a wake-up reason appeared
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module wfi_sleep_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Writeback stage
  input  logic                  wb_valid_i,
  input  logic                  wb_err_i,
  input  logic                  wb_kill_i,
  input  core_pkg::instr_t      wb_instr_i,

  // Privilege and CSR state
  input  core_pkg::priv_lvl_e   priv_lvl_i,
  input  logic                  mstatus_tw_i,

  // Debug
  input  logic                  debug_mode_i,
  input  logic                  debug_req_i,

  // Interrupt wake-up source
  input  irq_pkg::irq_vec_t     pend_en_i,

  // Bus and store path state
  input  core_pkg::outst_cnt_t  instr_outst_i,
  input  logic                  lsu_busy_i,
  input  logic                  wbuf_empty_i,

  // Sleep status
  output logic                  core_sleep_o,
  output logic                  wfi_retire_o
);

  logic                wfi_in_wb;
  logic                tw_trap;
  core_pkg::wfi_cnt_t  wfi_cnt_q;
  logic                outst_now;
  logic                outst_q;
  logic                blocked;
  logic                wake;

  // --------------------------------------------------------------------------
  // WFI detection
  // --------------------------------------------------------------------------

  // WFI in U-mode with mstatus.tw set traps instead of sleeping
  assign tw_trap = (priv_lvl_i == core_pkg::PRIV_LVL_U) && mstatus_tw_i;

  // No sleeping in debug mode
  assign wfi_in_wb = wb_valid_i                         &&
                     (wb_instr_i == core_pkg::WfiInstr) &&
                     !wb_err_i                          &&
                     !wb_kill_i                         &&
                     !debug_mode_i                      &&
                     !tw_trap;

  // --------------------------------------------------------------------------
  // Residence counter
  // --------------------------------------------------------------------------

  // Counts earlier consecutive writeback cycles, saturates at its maximum
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wfi_cnt_q <= '0;
    end else if (!wfi_in_wb) begin
      wfi_cnt_q <= '0;
    end else if (wfi_cnt_q != '1) begin
      wfi_cnt_q <= wfi_cnt_q + 2'd1;
    end
  end

  // --------------------------------------------------------------------------
  // Blocking conditions
  // --------------------------------------------------------------------------

  assign outst_now = |instr_outst_i;

  // Outstanding fetches also block the cycle after they drain
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= 1'b0;
    end else begin
      outst_q <= outst_now;
    end
  end

  assign blocked = outst_now   ||
                   outst_q     ||
                   lsu_busy_i  ||
                   !wbuf_empty_i;

  // --------------------------------------------------------------------------
  // Wake-up and outputs
  // --------------------------------------------------------------------------

  // Enabled interrupts wake regardless of mstatus.mie
  assign wake = (|pend_en_i) || debug_req_i;

  assign core_sleep_o = wfi_in_wb                            &&
                        (wfi_cnt_q >= core_pkg::WfiSleepDelay) &&
                        !blocked                             &&
                        !wake;

  // Retirement needs at least one earlier cycle in writeback
  assign wfi_retire_o = wfi_in_wb && (wfi_cnt_q != '0) && wake;

endmodule

// File: hw/irq_wfi_top.sv
// --------------------------------------------------------------------------
// Interrupt and sleep controller top level. Joins the pending register,
// the arbiter and the WFI sleep controller for a machine-mode core
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module irq_wfi_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Interrupt lines and CSR state
  input  irq_pkg::irq_vec_t     irq_i,
  input  irq_pkg::irq_vec_t     mie_i,
  input  logic                  mstatus_mie_i,
  input  logic                  mstatus_tw_i,
  input  core_pkg::priv_lvl_e   priv_lvl_i,
  output irq_pkg::irq_vec_t     mip_o,

  // Interrupt handshake with the core
  output logic                  irq_req_o,
  output irq_pkg::irq_id_t      irq_id_o,
  input  logic                  irq_ack_i,

  // Writeback stage
  input  logic                  wb_valid_i,
  input  logic                  wb_err_i,
  input  logic                  wb_kill_i,
  input  core_pkg::instr_t      wb_instr_i,

  // Debug
  input  logic                  debug_mode_i,
  input  logic                  debug_req_i,

  // Bus and store path state
  input  core_pkg::outst_cnt_t  instr_outst_i,
  input  logic                  lsu_busy_i,
  input  logic                  wbuf_empty_i,

  // Sleep status
  output logic                  core_sleep_o,
  output logic                  wfi_retire_o
);

  // Shared by arbitration and wake-up
  irq_pkg::irq_vec_t pend_en;

  irq_pending irq_pending_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .irq_i     (irq_i),
    .mie_i     (mie_i),
    .mip_o     (mip_o),
    .pend_en_o (pend_en)
  );

  irq_arbiter irq_arbiter_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pend_en_i     (pend_en),
    .priv_lvl_i    (priv_lvl_i),
    .mstatus_mie_i (mstatus_mie_i),
    .irq_req_o     (irq_req_o),
    .irq_id_o      (irq_id_o),
    .irq_ack_i     (irq_ack_i)
  );

  wfi_sleep_ctrl wfi_sleep_ctrl_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_valid_i    (wb_valid_i),
    .wb_err_i      (wb_err_i),
    .wb_kill_i     (wb_kill_i),
    .wb_instr_i    (wb_instr_i),
    .priv_lvl_i    (priv_lvl_i),
    .mstatus_tw_i  (mstatus_tw_i),
    .debug_mode_i  (debug_mode_i),
    .debug_req_i   (debug_req_i),
    .pend_en_i     (pend_en),
    .instr_outst_i (instr_outst_i),
    .lsu_busy_i    (lsu_busy_i),
    .wbuf_empty_i  (wbuf_empty_i),
    .core_sleep_o  (core_sleep_o),
    .wfi_retire_o  (wfi_retire_o)
  );

endmodule

// File: tb/irq_wfi_model.svh
// --------------------------------------------------------------------------
// Reference model of the interrupt and sleep controller. Included into the
// testbench module, it reads the DUT inputs and is stepped once per clock
// --------------------------------------------------------------------------

`ifndef IRQ_WFI_MODEL_SVH
`define IRQ_WFI_MODEL_SVH

irq_pkg::irq_vec_t       m_mip;
irq_pkg::irq_req_state_e m_state;
irq_pkg::irq_id_t        m_id;
core_pkg::wfi_cnt_t      m_cnt;
logic                    m_outst_q;

// Line at rank r of the order 31..16, 11, 3, 7
function automatic int unsigned rank_line(input int unsigned r);
  rank_line = (r < 16) ? 31 - r : (r == 16) ? 11 : (r == 17) ? 3 : 7;
endfunction

// Only ranked lines exist, all others are reserved
function automatic irq_pkg::irq_vec_t ranked_lines();
  irq_pkg::irq_vec_t v;
  v = '0;
  for (int r = 0; r < 19; r++) begin
    v[rank_line(r)] = 1'b1;
  end
  return v;
endfunction

// Walks the rank list 31..16, 11, 3, 7 and stops at the first pending line
function automatic logic find_winner(input irq_pkg::irq_vec_t v, output irq_pkg::irq_id_t id);
  int unsigned line;
  for (int r = 0; r < 19; r++) begin
    line = rank_line(r);
    if (v[line]) begin
      id = irq_pkg::irq_id_t'(line);
      return 1'b1;
    end
  end
  id = '0;
  return 1'b0;
endfunction

function automatic logic wfi_now();
  wfi_now = wb_valid_i && (wb_instr_i == core_pkg::WfiInstr) && !wb_err_i && !wb_kill_i &&
            !debug_mode_i && !((priv_lvl_i == core_pkg::PRIV_LVL_U) && mstatus_tw_i);
endfunction

function automatic logic wake_now();
  wake_now = ((m_mip & mie_i) != '0) || debug_req_i;
endfunction

function automatic logic sleep_now();
  sleep_now = wfi_now() && (m_cnt >= core_pkg::WfiSleepDelay) && (instr_outst_i == '0) &&
              !m_outst_q && !lsu_busy_i && wbuf_empty_i && !wake_now();
endfunction

function automatic logic retire_now();
  retire_now = wfi_now() && (m_cnt != '0) && wake_now();
endfunction

task automatic model_reset();
  m_mip     = '0;
  m_state   = irq_pkg::IDLE;
  m_id      = '0;
  m_cnt     = '0;
  m_outst_q = 1'b0;
endtask

// Called at the rising edge, before the inputs of the new cycle are driven
task automatic model_update();
  irq_pkg::irq_id_t win;
  logic             found;
  logic             elig;
  found = find_winner(m_mip & mie_i, win);
  elig  = found && ((priv_lvl_i == core_pkg::PRIV_LVL_U) || mstatus_mie_i);
  case (m_state)
    irq_pkg::IDLE: begin
      if (elig) begin
        m_state = irq_pkg::REQ;
        m_id    = win;
      end
    end
    irq_pkg::REQ:          if (irq_ack_i) m_state = irq_pkg::WAIT_ACK_LOW;
    irq_pkg::WAIT_ACK_LOW: if (!irq_ack_i) m_state = irq_pkg::IDLE;
    default:               m_state = irq_pkg::IDLE;
  endcase
  if (!wfi_now()) begin
    m_cnt = '0;
  end else if (m_cnt != 2'd3) begin
    m_cnt = m_cnt + 2'd1;
  end
  m_outst_q = (instr_outst_i != '0);
  m_mip     = irq_i & ranked_lines();
endtask

`endif

// File: tb/tb_irq_wfi.sv
// --------------------------------------------------------------------------
// Testbench for the interrupt and sleep controller. Random stimulus with a
// core-side ack responder, then a directed WFI sleep and wake-up sequence
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_irq_wfi;

  localparam int unsigned RandCycles = 3000;
  localparam int unsigned WaitLimit  = 20;

  logic                 clk_i;
  logic                 rst_ni;
  irq_pkg::irq_vec_t    irq_i;
  irq_pkg::irq_vec_t    mie_i;
  logic                 mstatus_mie_i;
  logic                 mstatus_tw_i;
  core_pkg::priv_lvl_e  priv_lvl_i;
  irq_pkg::irq_vec_t    mip_o;
  logic                 irq_req_o;
  irq_pkg::irq_id_t     irq_id_o;
  logic                 irq_ack_i;
  logic                 wb_valid_i;
  logic                 wb_err_i;
  logic                 wb_kill_i;
  core_pkg::instr_t     wb_instr_i;
  logic                 debug_mode_i;
  logic                 debug_req_i;
  core_pkg::outst_cnt_t instr_outst_i;
  logic                 lsu_busy_i;
  logic                 wbuf_empty_i;
  logic                 core_sleep_o;
  logic                 wfi_retire_o;

  integer               seed;
  logic                 ack_next;
  int unsigned          ack_wait;
  logic                 prev_req;
  logic                 prev_ack;
  logic                 prev_gie;
  core_pkg::priv_lvl_e  prev_priv;
  irq_pkg::irq_id_t     prev_id;
  int unsigned          u_rise_cnt;
  logic                 seg_quiet;

  irq_wfi_top irq_wfi_top_inst (.*);

  always #5 clk_i = ~clk_i;

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped after the first error");
  endtask

  task automatic check_vec(input irq_pkg::irq_vec_t got, input irq_pkg::irq_vec_t exp,
                           input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_id(input irq_pkg::irq_id_t got, input irq_pkg::irq_id_t exp,
                          input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  function automatic logic one_in(input int unsigned n);
    one_in = (next_rand() % n) == 0;
  endfunction

  `include "irq_wfi_model.svh"

  // Idle core with no WFI, no enabled interrupts and quiet buses
  task automatic quiet_inputs();
    irq_i         = '0;
    mie_i         = '0;
    mstatus_mie_i = 1'b0;
    mstatus_tw_i  = 1'b0;
    priv_lvl_i    = core_pkg::PRIV_LVL_M;
    wb_valid_i    = 1'b0;
    wb_err_i      = 1'b0;
    wb_kill_i     = 1'b0;
    wb_instr_i    = '0;
    debug_mode_i  = 1'b0;
    debug_req_i   = 1'b0;
    instr_outst_i = '0;
    lsu_busy_i    = 1'b0;
    wbuf_empty_i  = 1'b1;
  endtask

  // Model steps on the edge and the inputs change 1 ns later
  task automatic cycle_start();
    @(posedge clk_i);
    model_update();
    #1;
    irq_ack_i = ack_next;
  endtask

  // Outputs are compared at the falling edge, where they are settled
  task automatic cycle_end();
    logic rose;
    @(negedge clk_i);
    check_vec(mip_o, m_mip, "mip_o");
    check_bit(irq_req_o, m_state == irq_pkg::REQ, "irq_req_o");
    check_id(irq_id_o, m_id, "irq_id_o");
    check_bit(core_sleep_o, sleep_now(), "core_sleep_o");
    check_bit(wfi_retire_o, retire_now(), "wfi_retire_o");
    rose = irq_req_o && !prev_req;
    if (rose && (irq_ack_i || prev_ack)) begin
      $display("irq_req_o rose while irq_ack_i was still high");
      abort_run();
    end
    if (rose && (prev_priv == core_pkg::PRIV_LVL_M) && !prev_gie) begin
      $display("irq_req_o rose in M-mode while mstatus.mie was low");
      abort_run();
    end
    if (rose && (prev_priv == core_pkg::PRIV_LVL_U)) u_rise_cnt++;
    if (prev_req && irq_req_o) check_id(irq_id_o, prev_id, "irq_id_o during request");
    if (prev_req && prev_ack) check_bit(irq_req_o, 1'b0, "irq_req_o one cycle after ack");
    // Core side acks after a random 0..3 cycles and releases once req is gone
    if (irq_req_o) begin
      if (rose) ack_wait = next_rand() % 4;
      if (ack_wait == 0) ack_next = 1'b1;
      else ack_wait--;
    end else begin
      ack_next = 1'b0;
    end
    prev_req  = irq_req_o;
    prev_ack  = irq_ack_i;
    prev_gie  = mstatus_mie_i;
    prev_priv = priv_lvl_i;
    prev_id   = irq_id_o;
  endtask

  task automatic drive_random(input logic new_seg);
    if (new_seg) begin
      seg_quiet     = one_in(2);
      mie_i         = next_rand();
      mstatus_mie_i = one_in(2);
      priv_lvl_i    = one_in(2) ? core_pkg::PRIV_LVL_U : core_pkg::PRIV_LVL_M;
    end
    // Sparse lines so that single winners and ties both occur
    irq_i         = seg_quiet ? '0 : (next_rand() & next_rand() & next_rand());
    mstatus_tw_i  = one_in(4);
    wb_valid_i    = !one_in(8);
    wb_instr_i    = one_in(4) ? next_rand() : core_pkg::WfiInstr;
    wb_err_i      = one_in(16);
    wb_kill_i     = one_in(16);
    debug_mode_i  = one_in(16);
    debug_req_i   = one_in(16);
    instr_outst_i = one_in(8) ? core_pkg::outst_cnt_t'(next_rand()) : 2'd0;
    lsu_busy_i    = one_in(8);
    wbuf_empty_i  = !one_in(8);
  endtask

  task automatic wait_idle();
    int unsigned n;
    n = 0;
    while ((irq_req_o || irq_ack_i || (m_state != irq_pkg::IDLE)) && (n < WaitLimit)) begin
      cycle_start();
      cycle_end();
      n++;
    end
    if (irq_req_o || irq_ack_i || (m_state != irq_pkg::IDLE)) begin
      $display("timeout waiting for the request handshake to finish");
      abort_run();
    end
  endtask

  task automatic expect_sleep(input logic sleep, input logic retire, input string what);
    check_bit(core_sleep_o, sleep, {what, ", core_sleep_o"});
    check_bit(wfi_retire_o, retire, {what, ", wfi_retire_o"});
  endtask

  task automatic set_block(input int kind, input logic on);
    case (kind)
      0:       lsu_busy_i    = on;
      1:       wbuf_empty_i  = !on;
      default: instr_outst_i = on ? 2'd1 : 2'd0;
    endcase
  endtask

  task automatic run_sleep_test();
    cycle_start();
    quiet_inputs();
    cycle_end();
    wait_idle();
    cycle_start();
    wb_valid_i = 1'b1;
    wb_instr_i = core_pkg::WfiInstr;
    cycle_end();
    expect_sleep(1'b0, 1'b0, "first WFI cycle");
    for (int i = 2; i <= 3; i++) begin
      cycle_start();
      cycle_end();
      expect_sleep(i == 3, 1'b0, "held WFI");
    end
    // Outstanding fetches still block one cycle after they drain
    for (int k = 0; k < 3; k++) begin
      cycle_start();
      set_block(k, 1'b1);
      cycle_end();
      expect_sleep(1'b0, 1'b0, "blocked");
      cycle_start();
      set_block(k, 1'b0);
      cycle_end();
      expect_sleep(k != 2, 1'b0, "unblocked");
    end
    cycle_start();
    cycle_end();
    expect_sleep(1'b1, 1'b0, "fetches drained");
    cycle_start();
    debug_req_i = 1'b1;
    cycle_end();
    expect_sleep(1'b0, 1'b1, "debug request");
    cycle_start();
    debug_req_i = 1'b0;
    cycle_end();
    expect_sleep(1'b1, 1'b0, "debug request gone");
    // Interrupt wakes one cycle later even with mstatus.mie low
    cycle_start();
    mie_i = 32'h0000_0800;
    irq_i = 32'h0000_0800;
    cycle_end();
    expect_sleep(1'b1, 1'b0, "line 11 raised");
    cycle_start();
    cycle_end();
    expect_sleep(1'b0, 1'b1, "line 11 in mip");
    cycle_start();
    quiet_inputs();
    cycle_end();
    wait_idle();
  endtask

  initial begin
    seed       = 32'ha34cf55a;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    irq_ack_i  = 1'b0;
    quiet_inputs();
    ack_next   = 1'b0;
    ack_wait   = 0;
    prev_req   = 1'b0;
    prev_ack   = 1'b0;
    prev_gie   = 1'b0;
    prev_priv  = core_pkg::PRIV_LVL_M;
    prev_id    = '0;
    u_rise_cnt = 0;
    seg_quiet  = 1'b1;
    model_reset();
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    for (int n = 0; n < RandCycles; n++) begin
      cycle_start();
      drive_random(n % 16 == 0);
      cycle_end();
    end
    run_sleep_test();
    if (u_rise_cnt == 0) begin
      $display("no interrupt request was raised in U-mode");
      abort_run();
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: src.f
+incdir+tb
common/irq_pkg.sv
common/core_pkg.sv
hw/irq_ctrl/irq_pending.sv
hw/irq_ctrl/irq_arbiter.sv
hw/sleep_ctrl/wfi_sleep_ctrl.sv
hw/irq_wfi_top.sv
tb/tb_irq_wfi.sv
